//--- verilog.f
verilog/rd_arb_pkg.sv
verilog/rd_lock_tracker.sv
verilog/rd_rr_select.sv
verilog/rd_grant_fsm.sv
verilog/rd_arbiter.sv
verification/tb_clock_gen.sv
verification/rd_arbiter_assert.sv
verification/tb_rd_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# Builds the read arbiter testbench with Verilator and runs it.
# Exits non-zero when the build fails or the run reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_rd_arbiter

verilator --binary --timing --assert \
   --top-module tb_rd_arbiter \
   -f verilog.f \
   -o sim_rd_arbiter
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "RESULT: FAIL (simulator exited with status $run_status)"
   exit 1
fi

if ! grep -q "Simulation passed" "$LOG"; then
   echo "RESULT: FAIL (no pass message in $LOG)"
   exit 1
fi

echo "RESULT: PASS"
exit 0

//--- verification/tb_rd_arbiter.sv
// Table-driven testbench for the four-master read arbiter.
// Each table row is driven on a falling edge and the grant it produces
// is checked at the following falling edge. Stops at the first mismatch.

`timescale 1ns/1ps

module tb_rd_arbiter;

   import rd_arb_pkg::*;

   localparam int RESET_CYCLES   = 10;
   localparam int TIMEOUT_MARGIN = 20;

   // --------------------------------------------------
   // Per-master stimulus codes
   // --------------------------------------------------
   localparam rd_master_t M_IDLE    = '{req: 1'b0, lock: NORMAL,    rd_end: 1'b0};
   localparam rd_master_t M_END     = '{req: 1'b0, lock: NORMAL,    rd_end: 1'b1};
   localparam rd_master_t M_RD      = '{req: 1'b1, lock: NORMAL,    rd_end: 1'b0};
   localparam rd_master_t M_RD_END  = '{req: 1'b1, lock: NORMAL,    rd_end: 1'b1};
   localparam rd_master_t M_LK      = '{req: 1'b1, lock: LOCKED,    rd_end: 1'b0};
   localparam rd_master_t M_LK_END  = '{req: 1'b1, lock: LOCKED,    rd_end: 1'b1};
   localparam rd_master_t M_EX      = '{req: 1'b1, lock: EXCLUSIVE, rd_end: 1'b0};
   localparam rd_master_t M_EX_END  = '{req: 1'b1, lock: EXCLUSIVE, rd_end: 1'b1};

   typedef struct packed {
      rd_master_vec_t masters;
      master_vec_t    exp_grant;
   } stim_row_t;

   logic           ACLK;
   logic           aresetn;
   rd_master_vec_t masters;
   master_vec_t    grant;

   stim_row_t      rows[$];
   int             cycle_count   = 0;
   int             timeout_limit = 1000;

   tb_clock_gen u_clock_gen (
      .ACLK    (ACLK),
      .aresetn (aresetn)
   );

   rd_arbiter DUT (
      .ACLK    (ACLK),
      .aresetn (aresetn),
      .masters (masters),
      .grant   (grant)
   );

   // --------------------------------------------------
   // Failure handling and checks
   // --------------------------------------------------
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_grant(input master_vec_t expected, input master_vec_t actual,
                              input string where);
      if (actual !== expected) begin
         abort_run($sformatf("error: grant at %s expected 0x%h got 0x%h",
                             where, expected, actual));
      end
   endtask

   // --------------------------------------------------
   // Stimulus table
   // --------------------------------------------------
   task automatic add_row(input master_vec_t exp_grant, input rd_master_t m0,
                          input rd_master_t m1, input rd_master_t m2, input rd_master_t m3);
      stim_row_t row;
      row.masters[0] = m0;
      row.masters[1] = m1;
      row.masters[2] = m2;
      row.masters[3] = m3;
      row.exp_grant  = exp_grant;
      rows.push_back(row);
   endtask

   // Expected grant is bit 3 down to 0, masters are listed 0 to 3
   task automatic build_table();
      // Idle after reset
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);

      // Round robin with all four requesting, search starts at master 0
      add_row(4'b0001, M_RD, M_RD, M_RD, M_RD);
      add_row(4'b0000, M_RD_END, M_RD, M_RD, M_RD);
      add_row(4'b0010, M_RD, M_RD, M_RD, M_RD);
      add_row(4'b0000, M_RD, M_RD_END, M_RD, M_RD);
      add_row(4'b0100, M_RD, M_RD, M_RD, M_RD);
      add_row(4'b0000, M_RD, M_RD, M_RD_END, M_RD);
      add_row(4'b1000, M_RD, M_RD, M_RD, M_RD);
      add_row(4'b0000, M_RD, M_RD, M_RD, M_RD_END);
      add_row(4'b0001, M_RD, M_RD, M_RD, M_RD);
      add_row(4'b0000, M_RD_END, M_RD, M_RD, M_RD);
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);

      // Master 2 alone, held until its read end
      add_row(4'b0100, M_IDLE, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0100, M_IDLE, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0100, M_IDLE, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_RD_END, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);

      // Locked sequence on master 1
      add_row(4'b0010, M_IDLE, M_LK, M_IDLE, M_IDLE);
      add_row(4'b0010, M_RD, M_LK, M_IDLE, M_RD);
      add_row(4'b0010, M_RD, M_LK_END, M_IDLE, M_RD);
      // First unlocked request is only seen at the next edge
      add_row(4'b0010, M_RD, M_RD_END, M_IDLE, M_RD);
      add_row(4'b0000, M_RD, M_RD_END, M_IDLE, M_RD);
      add_row(4'b1000, M_RD, M_IDLE, M_IDLE, M_RD);

      // Strobes from non-owners and exclusive requests
      add_row(4'b1000, M_RD_END, M_END, M_IDLE, M_RD);
      add_row(4'b1000, M_EX, M_IDLE, M_END, M_RD);
      add_row(4'b0000, M_LK, M_IDLE, M_IDLE, M_RD_END);
      add_row(4'b0001, M_LK, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b0001, M_EX_END, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0001, M_EX_END, M_END, M_RD, M_IDLE);
      add_row(4'b0001, M_RD, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0000, M_EX_END, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0100, M_IDLE, M_IDLE, M_RD, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_RD_END, M_IDLE);

      // Gap, then the search resumes after master 2
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b1000, M_RD, M_IDLE, M_IDLE, M_RD);
      add_row(4'b0000, M_RD, M_IDLE, M_IDLE, M_RD_END);
      add_row(4'b0001, M_RD, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b0000, M_RD_END, M_IDLE, M_IDLE, M_IDLE);
      add_row(4'b0000, M_IDLE, M_IDLE, M_IDLE, M_IDLE);
   endtask

   // Idle masters get a random lock field, which the arbiter ignores
   task automatic drive_row(input rd_master_vec_t row);
      rd_master_vec_t m;
      m = row;
      for (int i = 0; i < NUM_MASTERS; i++) begin
         if (!m[i].req) begin
            m[i].lock = lock_e'(2'($urandom_range(2, 0)));
         end
      end
      masters = m;
   endtask

   // --------------------------------------------------
   // Timeout
   // --------------------------------------------------
   always @(posedge ACLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         abort_run($sformatf("Timeout after %0d cycles before the stimulus table finished",
                             cycle_count));
      end
   end

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      masters = '0;
      void'($urandom(32'h1fc4a2b9));
      build_table();
      timeout_limit = RESET_CYCLES + rows.size() + TIMEOUT_MARGIN;

      // Grant stays zero for as long as reset is held
      @(negedge ACLK);
      while (!aresetn) begin
         check_grant('0, grant, "reset");
         @(negedge ACLK);
      end

      drive_row(rows[0].masters);
      for (int i = 0; i < rows.size(); i++) begin
         @(negedge ACLK);
         check_grant(rows[i].exp_grant, grant, $sformatf("row %0d", i));
         if (i + 1 < rows.size()) begin
            drive_row(rows[i + 1].masters);
         end else begin
            masters = '0;
         end
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

//--- verification/rd_arbiter_assert.sv
// Protocol checks on the read arbiter grant output.
// Bound to every rd_arbiter instance by the bind at the end of this file.

`timescale 1ns/1ps

module rd_arbiter_assert (
   input logic                    ACLK,
   input logic                    aresetn,
   input rd_arb_pkg::master_vec_t grant
);

   // At most one owner at any time
   grant_onehot: assert property (
      @(posedge ACLK) disable iff (!aresetn) $onehot0(grant)
   ) else $error("grant has more than one bit set, value 0x%h", grant);

   // Ownership changes always pass through a zero-grant cycle
   grant_handoff: assert property (
      @(posedge ACLK) disable iff (!aresetn)
      (grant != '0) |=> ((grant == '0) || (grant == $past(grant)))
   ) else $error("grant moved between masters without a zero cycle, now 0x%h", grant);

   // Nothing is granted while reset is held
   grant_in_reset: assert property (
      @(posedge ACLK) !aresetn |-> (grant == '0)
   ) else $error("grant is not zero during reset, value 0x%h", grant);

endmodule

bind rd_arbiter rd_arbiter_assert u_arbiter_assert (
   .ACLK    (ACLK),
   .aresetn (aresetn),
   .grant   (grant)
);

//--- verification/tb_clock_gen.sv
// Clock and reset source for the read arbiter testbench.
// ACLK runs with a 100 ns period and aresetn is held low for the
// first 10 rising edges, then released on a falling edge.

`timescale 1ns/1ps

module tb_clock_gen (
   output logic ACLK,
   output logic aresetn
);

   localparam int HALF_PERIOD_NS = 50;
   localparam int RESET_CYCLES   = 10;

   initial begin
      ACLK = 1'b0;
      forever #(HALF_PERIOD_NS) ACLK = ~ACLK;
   end

   // Release away from the rising edge the DUT samples on
   initial begin
      aresetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge ACLK);
      @(negedge ACLK);
      aresetn <= 1'b1;
   end

endmodule

//--- verilog/rd_arbiter.sv
// Four-master AXI read-address arbiter, top level.
// Grants the shared read channel to one master at a time in round-robin
// order and holds the grant across locked read sequences.
// grant is registered and is zero or one-hot.

`timescale 1ns/1ps

module rd_arbiter (
   input  logic                       ACLK,
   input  logic                       aresetn,
   input  rd_arb_pkg::rd_master_vec_t masters,
   output rd_arb_pkg::master_vec_t    grant
);

   import rd_arb_pkg::*;

   master_vec_t req_vec;
   master_vec_t locked_req;
   master_vec_t release_ok;
   logic        win_valid;
   master_idx_t win_idx;
   logic        grant_taken;
   master_idx_t owner_idx;

   // Request levels for the selector
   always_comb begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
         req_vec[i] = masters[i].req;
      end
   end

   // --------------------------------------------------
   // Lock status and round-robin search run side by side
   // --------------------------------------------------
   rd_lock_tracker u_lock_tracker (
      .ACLK       (ACLK),
      .aresetn    (aresetn),
      .masters    (masters),
      .locked_req (locked_req),
      .release_ok (release_ok)
   );

   rd_rr_select u_rr_select (
      .ACLK        (ACLK),
      .aresetn     (aresetn),
      .req         (req_vec),
      .grant_taken (grant_taken),
      .owner_idx   (owner_idx),
      .win_valid   (win_valid),
      .win_idx     (win_idx)
   );

   // --------------------------------------------------
   // Grant FSM
   // --------------------------------------------------
   rd_grant_fsm u_grant_fsm (
      .ACLK        (ACLK),
      .aresetn     (aresetn),
      .masters     (masters),
      .win_valid   (win_valid),
      .win_idx     (win_idx),
      .locked_req  (locked_req),
      .release_ok  (release_ok),
      .grant_taken (grant_taken),
      .owner_idx   (owner_idx),
      .grant       (grant)
   );

endmodule

//--- verilog/rd_grant_fsm.sv
// Grant state machine of the read arbiter.
// Combines the round-robin winner with the lock status and the read-end
// strobes into one registered one-hot grant. A zero-grant cycle always
// separates two owners. Pulses grant_taken one cycle after a new grant.

`timescale 1ns/1ps

module rd_grant_fsm (
   input  logic                       ACLK,
   input  logic                       aresetn,
   input  rd_arb_pkg::rd_master_vec_t masters,
   input  logic                       win_valid,
   input  rd_arb_pkg::master_idx_t    win_idx,
   input  rd_arb_pkg::master_vec_t    locked_req,
   input  rd_arb_pkg::master_vec_t    release_ok,
   output logic                       grant_taken,
   output rd_arb_pkg::master_idx_t    owner_idx,
   output rd_arb_pkg::master_vec_t    grant
);

   import rd_arb_pkg::*;

   grant_state_e state_q;
   grant_state_e state_nxt;

   master_idx_t  owner_q;
   master_idx_t  owner_nxt;
   master_vec_t  grant_q;
   master_vec_t  grant_nxt;
   logic         taken_q;
   logic         taken_nxt;

   // Read end from the current owner only
   logic         owner_end;

   assign owner_end = masters[owner_q].rd_end;

   // --------------------------------------------------
   // Next state
   // --------------------------------------------------
   always_comb begin
      state_nxt = state_q;
      owner_nxt = owner_q;
      grant_nxt = grant_q;
      taken_nxt = 1'b0;

      case (state_q)
         ARB_IDLE: begin
            if (win_valid) begin
               owner_nxt = win_idx;
               grant_nxt = master_vec_t'(1) << win_idx;
               taken_nxt = 1'b1;
               if (locked_req[win_idx]) begin
                  state_nxt = ARB_LOCKED;
               end else begin
                  state_nxt = ARB_OWNED;
               end
            end
         end

         ARB_OWNED: begin
            if (owner_end) begin
               grant_nxt = '0;
               state_nxt = ARB_IDLE;
            end
         end

         // Held until an unlocked request has been seen and a read ends
         ARB_LOCKED: begin
            if (owner_end && release_ok[owner_q]) begin
               grant_nxt = '0;
               state_nxt = ARB_IDLE;
            end
         end

         default: begin
            grant_nxt = '0;
            state_nxt = ARB_IDLE;
         end
      endcase
   end

   // --------------------------------------------------
   // State and output registers
   // --------------------------------------------------
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         state_q <= ARB_IDLE;
         owner_q <= '0;
         grant_q <= '0;
         taken_q <= 1'b0;
      end else begin
         state_q <= state_nxt;
         owner_q <= owner_nxt;
         grant_q <= grant_nxt;
         taken_q <= taken_nxt;
      end
   end

   assign grant       = grant_q;
   assign owner_idx   = owner_q;
   assign grant_taken = taken_q;

endmodule

//--- verilog/rd_rr_select.sv
// Round-robin winner selection for the read arbiter.
// Keeps the index of the last granted master and searches the request
// vector from the next index onwards, wrapping, so the last owner is
// checked last. The winner is combinational from requests and pointer.

`timescale 1ns/1ps

module rd_rr_select (
   input  logic                    ACLK,
   input  logic                    aresetn,
   input  rd_arb_pkg::master_vec_t req,
   input  logic                    grant_taken,
   input  rd_arb_pkg::master_idx_t owner_idx,
   output logic                    win_valid,
   output rd_arb_pkg::master_idx_t win_idx
);

   import rd_arb_pkg::*;

   // Last granted master
   master_idx_t rr_ptr;

   // Candidate index during the search
   master_idx_t scan_idx;

   // --------------------------------------------------
   // Priority pointer
   // --------------------------------------------------
   // Resets to the highest index so that master 0 is searched first
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         rr_ptr <= master_idx_t'(NUM_MASTERS - 1);
      end else if (grant_taken) begin
         rr_ptr <= owner_idx;
      end
   end

   // --------------------------------------------------
   // Rotating priority search
   // --------------------------------------------------
   // Offsets 1 .. NUM_MASTERS from the pointer; the index wraps on the
   // index width, so the final offset lands on the pointer itself
   always_comb begin
      win_valid = 1'b0;
      win_idx   = '0;
      scan_idx  = '0;
      for (int k = 1; k <= NUM_MASTERS; k++) begin
         scan_idx = rr_ptr + master_idx_t'(k);
         if (!win_valid && req[scan_idx]) begin
            win_valid = 1'b1;
            win_idx   = scan_idx;
         end
      end
   end

endmodule

//--- verilog/rd_lock_tracker.sv
// Lock tracking for the read arbiter.
// Flags which masters request a locked sequence and keeps, per master,
// a flag that allows a locked sequence to be released.

`timescale 1ns/1ps

module rd_lock_tracker (
   input  logic                       ACLK,
   input  logic                       aresetn,
   input  rd_arb_pkg::rd_master_vec_t masters,
   output rd_arb_pkg::master_vec_t    locked_req,
   output rd_arb_pkg::master_vec_t    release_ok
);

   import rd_arb_pkg::*;

   master_vec_t release_q;

   // --------------------------------------------------
   // Locked request decode
   // --------------------------------------------------
   always_comb begin
      for (int i = 0; i < NUM_MASTERS; i++) begin
         locked_req[i] = masters[i].req && (masters[i].lock == LOCKED);
      end
   end

   // --------------------------------------------------
   // Release flags
   // --------------------------------------------------
   // A LOCKED request clears the flag and a NORMAL request sets it.
   // EXCLUSIVE requests keep whatever was there before
   always_ff @(posedge ACLK or negedge aresetn) begin
      if (!aresetn) begin
         release_q <= '0;
      end else begin
         for (int i = 0; i < NUM_MASTERS; i++) begin
            if (masters[i].req) begin
               if (masters[i].lock == LOCKED) begin
                  release_q[i] <= 1'b0;
               end else if (masters[i].lock == NORMAL) begin
                  release_q[i] <= 1'b1;
               end
            end
         end
      end
   end

   assign release_ok = release_q;

endmodule

//--- verilog/rd_arb_pkg.sv
// Shared types and constants for the four-master AXI read-address arbiter.
// Every arbiter module imports this package. Ports name its types by
// scope and module bodies pull them in with a wildcard import.

package rd_arb_pkg;

   // --------------------------------------------------
   // Sizes
   // --------------------------------------------------
   localparam int NUM_MASTERS  = 4;
   localparam int MASTER_IDX_W = 2;

   // Index of one master
   typedef logic [MASTER_IDX_W-1:0] master_idx_t;

   // One bit per master, used for request, lock, release and grant vectors
   typedef logic [NUM_MASTERS-1:0] master_vec_t;

   // --------------------------------------------------
   // AXI lock field
   // --------------------------------------------------
   // Encoded as AR lock. Value 2'b11 is reserved and treated like EXCLUSIVE
   typedef enum logic [1:0] {
      NORMAL    = 2'b00,
      EXCLUSIVE = 2'b01,
      LOCKED    = 2'b10
   } lock_e;

   // --------------------------------------------------
   // Per-master inputs
   // --------------------------------------------------
   // req is a level held until granted.
   // rd_end is a one-cycle strobe at the end of a read
   typedef struct packed {
      logic  req;
      lock_e lock;
      logic  rd_end;
   } rd_master_t;

   // Master 0 sits at index 0
   typedef rd_master_t [NUM_MASTERS-1:0] rd_master_vec_t;

   // --------------------------------------------------
   // Grant FSM states
   // --------------------------------------------------
   // ARB_IDLE   no owner, grant is zero
   // ARB_OWNED  plain read in progress, ends on owner rd_end
   // ARB_LOCKED locked sequence, ends on rd_end after an unlocked request
   typedef enum logic [1:0] {
      ARB_IDLE   = 2'b00,
      ARB_OWNED  = 2'b01,
      ARB_LOCKED = 2'b10
   } grant_state_e;

endpackage
